/* hw/exec_defines.svh */
`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

`define EXEC_DATA_W 32
`define REG_AW      5
`define LP_REG      5'd30 // Link register.

`define ALU_OP_W  3
`define ALUSRC2_W 2
`define IMM_SEL_W 3
`define WRREG_W   2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Opcodes, instruction bits 30:25
`define OP_ADD   6'h00
`define OP_SUB   6'h01
`define OP_OR    6'h02
`define OP_ADDI  6'h08
`define OP_ORI   6'h09
`define OP_SLLI  6'h0a
`define OP_MOVI  6'h10
`define OP_SETHI 6'h11
`define OP_LWI   6'h18
`define OP_LW    6'h19
`define OP_JAL   6'h20

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mux select codes
`define ALUSRC2_RBDATA 2'd0
`define ALUSRC2_IMM    2'd1
`define ALUSRC2_LSWI   2'd2 // Word offset.
`define ALUSRC2_LSW    2'd3 // Scaled index.

`define IMM_5BIT_ZE  3'd0
`define IMM_15BIT_SE 3'd1
`define IMM_15BIT_ZE 3'd2
`define IMM_20BIT_SE 3'd3
`define IMM_20BIT_HI 3'd4

`define MADDR_ALURESULT 1'b0
`define MADDR_RADATA    1'b1

`define WRADDR_RT 1'b0
`define WRADDR_LP 1'b1

`define WRREG_ALURESULT 2'd0
`define WRREG_IMMDATA   2'd1
`define WRREG_MEM       2'd2
`define WRREG_PC        2'd3

`define ALU_ADD   3'd0
`define ALU_SUB   3'd1
`define ALU_OR    3'd2
`define ALU_SLL   3'd3
`define ALU_PASS2 3'd4

`endif

/* hw/exec_pkg.sv */
`include "exec_defines.svh"

package exec_pkg;

	typedef logic [`EXEC_DATA_W-1:0] word_t;
	typedef logic [`REG_AW-1:0]      reg_addr_t;
	typedef logic [`ALU_OP_W-1:0]    alu_op_t;
	typedef logic [`ALUSRC2_W-1:0]   src2_sel_t;
	typedef logic [`IMM_SEL_W-1:0]   imm_sel_t;
	typedef logic [`WRREG_W-1:0]     wrreg_sel_t;

	// Decoded control.
	typedef struct packed {
		alu_op_t    alu_op;
		src2_sel_t  sel_alu_src2;
		imm_sel_t   sel_imm_extend;
		logic       sel_mem_addr;
		logic       sel_write_reg_addr;
		wrreg_sel_t sel_write_reg;
		logic       mem_read;
		logic       reg_write;
	} dec_ctrl_t;

	// Raw instruction fields.
	typedef struct packed {
		reg_addr_t   rt;
		reg_addr_t   ra;
		reg_addr_t   rb;
		logic [1:0]  sv;
		logic [4:0]  imm5;
		logic [14:0] imm15;
		logic [19:0] imm20;
	} dec_fields_t;

	// Write-back stage bundle.
	typedef struct packed {
		word_t     alu_result;
		word_t     imm_extend;
		word_t     ra_data;
		word_t     pc;
		dec_ctrl_t ctrl;
		reg_addr_t rt;
	} ex_stage_t;

endpackage

/* hw/inst_decoder.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module inst_decoder import exec_pkg::*; (
	input  word_t       inst,
	output dec_ctrl_t   ctrl,
	output dec_fields_t fields
);

	logic [5:0] opcode;

	assign opcode = inst[30:25];

	assign fields.rt    = inst[24:20];
	assign fields.ra    = inst[19:15];
	assign fields.rb    = inst[14:10];
	assign fields.sv    = inst[9:8];
	assign fields.imm5  = inst[14:10];
	assign fields.imm15 = inst[14:0];
	assign fields.imm20 = inst[19:0];

	always_comb begin
		ctrl = '0; // No write, no load.
		case (opcode)
			`OP_ADD, `OP_SUB, `OP_OR: begin
				ctrl.alu_op = (opcode == `OP_ADD) ? `ALU_ADD :
				              (opcode == `OP_SUB) ? `ALU_SUB : `ALU_OR;
				ctrl.sel_alu_src2 = `ALUSRC2_RBDATA;
				ctrl.reg_write    = 1'b1;
			end
			`OP_ADDI, `OP_ORI, `OP_SLLI: begin
				ctrl.alu_op = (opcode == `OP_ADDI) ? `ALU_ADD :
				              (opcode == `OP_ORI) ? `ALU_OR : `ALU_SLL;
				ctrl.sel_imm_extend = (opcode == `OP_ADDI) ? `IMM_15BIT_SE :
				                      (opcode == `OP_ORI) ? `IMM_15BIT_ZE : `IMM_5BIT_ZE;
				ctrl.sel_alu_src2 = `ALUSRC2_IMM;
				ctrl.reg_write    = 1'b1;
			end
			`OP_MOVI, `OP_SETHI: begin
				ctrl.alu_op = `ALU_PASS2;
				ctrl.sel_imm_extend = (opcode == `OP_MOVI) ? `IMM_20BIT_SE : `IMM_20BIT_HI;
				ctrl.sel_alu_src2   = `ALUSRC2_IMM;
				ctrl.sel_write_reg  = `WRREG_IMMDATA;
				ctrl.reg_write      = 1'b1;
			end
			`OP_LWI, `OP_LW: begin
				ctrl.alu_op = `ALU_ADD; // Base plus offset.
				ctrl.sel_alu_src2 = (opcode == `OP_LWI) ? `ALUSRC2_LSWI : `ALUSRC2_LSW;
				ctrl.sel_mem_addr  = `MADDR_ALURESULT;
				ctrl.sel_write_reg = `WRREG_MEM;
				ctrl.mem_read      = 1'b1;
				ctrl.reg_write     = 1'b1;
			end
			`OP_JAL: begin
				ctrl.sel_write_reg_addr = `WRADDR_LP;
				ctrl.sel_write_reg      = `WRREG_PC;
				ctrl.reg_write          = 1'b1;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module reg_file import exec_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	output word_t     ra_data,
	output word_t     rb_data,
	input  logic      we,
	input  reg_addr_t wr_addr,
	input  word_t     wr_data
);

	localparam int DEPTH = 1 << `REG_AW;

	word_t regs [0:DEPTH-1];
	logic  wr_en;

	assign wr_en = we && (wr_addr != '0); // r0 stays zero.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Write-first, so a read in the write cycle sees the new value.
	assign ra_data = (wr_en && wr_addr == ra_addr) ? wr_data : regs[ra_addr];
	assign rb_data = (wr_en && wr_addr == rb_addr) ? wr_data : regs[rb_addr];

endmodule

/* hw/operand_muxes.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module operand_muxes import exec_pkg::*; (
	input  src2_sel_t   sel_alu_src2,
	input  imm_sel_t    sel_imm_extend,
	input  logic [1:0]  sv,
	input  word_t       rb_data,
	input  word_t       rt_data,
	input  logic [4:0]  imm5,
	input  logic [14:0] imm15,
	input  logic [19:0] imm20,
	output word_t       imm_extend,
	output word_t       alu_src2
);

	always_comb begin
		case (sel_imm_extend)
			`IMM_5BIT_ZE: begin
				imm_extend = {27'b0, imm5};
			end
			`IMM_15BIT_SE: begin
				imm_extend = {{17{imm15[14]}}, imm15};
			end
			`IMM_15BIT_ZE: begin
				imm_extend = {17'b0, imm15};
			end
			`IMM_20BIT_SE: begin
				imm_extend = {{12{imm20[19]}}, imm20};
			end
			`IMM_20BIT_HI: begin
				imm_extend = {imm20, 12'b0}; // Upper bits, low zero.
			end
			default: begin
				imm_extend = '0;
			end
		endcase
	end

	always_comb begin
		case (sel_alu_src2)
			`ALUSRC2_RBDATA: begin
				alu_src2 = rb_data;
			end
			`ALUSRC2_IMM: begin
				alu_src2 = imm_extend;
			end
			`ALUSRC2_LSWI: begin
				alu_src2 = {{15{imm15[14]}}, imm15, 2'b00}; // Byte offset.
			end
			`ALUSRC2_LSW: begin
				alu_src2 = rb_data << sv;
			end
			default: begin
				alu_src2 = rt_data;
			end
		endcase
	end

endmodule

/* hw/exec_alu.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_alu import exec_pkg::*; (
	input  alu_op_t op,
	input  word_t   src1,
	input  word_t   src2,
	output word_t   result
);

	always_comb begin
		case (op)
			`ALU_ADD: begin
				result = src1 + src2;
			end
			`ALU_SUB: begin
				result = src1 - src2;
			end
			`ALU_OR: begin
				result = src1 | src2;
			end
			`ALU_SLL: begin
				result = src1 << src2[4:0]; // Low five bits only.
			end
			`ALU_PASS2: begin
				result = src2;
			end
			default: begin
				result = '0;
			end
		endcase
	end

endmodule

/* hw/writeback_select.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module writeback_select import exec_pkg::*; (
	input  logic       sel_mem_addr,
	input  logic       sel_write_reg_addr,
	input  wrreg_sel_t sel_write_reg,
	input  word_t      alu_result,
	input  word_t      ra_data,
	input  word_t      imm_extend,
	input  word_t      mem_rdata,
	input  word_t      pc,
	input  reg_addr_t  rt,
	output word_t      mem_addr,
	output word_t      wr_data,
	output reg_addr_t  wr_addr
);

	assign mem_addr = (sel_mem_addr == `MADDR_RADATA) ? ra_data : alu_result;

	assign wr_addr = (sel_write_reg_addr == `WRADDR_LP) ? `LP_REG : rt;

	always_comb begin
		case (sel_write_reg)
			`WRREG_ALURESULT: begin
				wr_data = alu_result;
			end
			`WRREG_IMMDATA: begin
				wr_data = imm_extend;
			end
			`WRREG_MEM: begin
				wr_data = mem_rdata;
			end
			`WRREG_PC: begin
				wr_data = pc + 32'd4; // Return address.
			end
			default: begin
				wr_data = '0;
			end
		endcase
	end

endmodule

/* hw/exec_slice.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module exec_slice import exec_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      in_valid,
	input  word_t     in_inst,
	input  word_t     in_pc,
	output logic      mem_re,
	output word_t     mem_addr,
	input  word_t     mem_rdata,
	output logic      wb_valid,
	output reg_addr_t wb_addr,
	output word_t     wb_data
);

	dec_ctrl_t   dec_ctrl;
	dec_fields_t dec_fields;
	word_t       rf_ra_data;
	word_t       rf_rb_data;

	logic        s1_valid;
	dec_ctrl_t   s1_ctrl;
	dec_fields_t s1_fields;
	word_t       s1_ra_data;
	word_t       s1_rb_data;
	word_t       s1_pc;

	word_t       imm_extend;
	word_t       alu_src2;
	word_t       alu_result;

	logic        ex_valid;
	ex_stage_t   ex;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1, decode and read
	inst_decoder u_dec (
		.inst   (in_inst),
		.ctrl   (dec_ctrl),
		.fields (dec_fields)
	);

	reg_file u_rf (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (dec_fields.ra),
		.rb_addr (dec_fields.rb),
		.ra_data (rf_ra_data),
		.rb_data (rf_rb_data),
		.we      (wb_valid),
		.wr_addr (wb_addr),
		.wr_data (wb_data)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			ex_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid;
			ex_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_ctrl    <= dec_ctrl;
			s1_fields  <= dec_fields;
			s1_ra_data <= rf_ra_data;
			s1_rb_data <= rf_rb_data;
			s1_pc      <= in_pc;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2, execute and address
	operand_muxes u_opmux (
		.sel_alu_src2   (s1_ctrl.sel_alu_src2),
		.sel_imm_extend (s1_ctrl.sel_imm_extend),
		.sv             (s1_fields.sv),
		.rb_data        (s1_rb_data),
		.rt_data        (s1_rb_data), // Port B doubles as rt source.
		.imm5           (s1_fields.imm5),
		.imm15          (s1_fields.imm15),
		.imm20          (s1_fields.imm20),
		.imm_extend     (imm_extend),
		.alu_src2       (alu_src2)
	);

	exec_alu u_alu (
		.op     (s1_ctrl.alu_op),
		.src1   (s1_ra_data),
		.src2   (alu_src2),
		.result (alu_result)
	);

	writeback_select u_maddr_sel (
		.sel_mem_addr       (s1_ctrl.sel_mem_addr),
		.sel_write_reg_addr (s1_ctrl.sel_write_reg_addr),
		.sel_write_reg      (s1_ctrl.sel_write_reg),
		.alu_result         (alu_result),
		.ra_data            (s1_ra_data),
		.imm_extend         (imm_extend),
		.mem_rdata          (mem_rdata),
		.pc                 (s1_pc),
		.rt                 (s1_fields.rt),
		.mem_addr           (mem_addr),
		.wr_data            (),
		.wr_addr            ()
	);

	assign mem_re = s1_valid && s1_ctrl.mem_read; // Read issues here.

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			ex.alu_result <= alu_result;
			ex.imm_extend <= imm_extend;
			ex.ra_data    <= s1_ra_data;
			ex.pc         <= s1_pc;
			ex.ctrl       <= s1_ctrl;
			ex.rt         <= s1_fields.rt;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 3, write-back
	writeback_select u_wb_sel (
		.sel_mem_addr       (ex.ctrl.sel_mem_addr),
		.sel_write_reg_addr (ex.ctrl.sel_write_reg_addr),
		.sel_write_reg      (ex.ctrl.sel_write_reg),
		.alu_result         (ex.alu_result),
		.ra_data            (ex.ra_data),
		.imm_extend         (ex.imm_extend),
		.mem_rdata          (mem_rdata), // Returned one cycle after mem_re.
		.pc                 (ex.pc),
		.rt                 (ex.rt),
		.mem_addr           (),
		.wr_data            (wb_data),
		.wr_addr            (wb_addr)
	);

	assign wb_valid = ex_valid && ex.ctrl.reg_write;

endmodule

/* bench/tb_exec_slice.sv */
`timescale 1ns/1ps
`include "exec_defines.svh"

module tb_exec_slice import exec_pkg::*; ();

	localparam int   NUM_TESTS      = 25;
	localparam int   TIMEOUT_CYCLES = NUM_TESTS * 6 + 50;
	localparam word_t MEM_XOR       = 32'h5a5a_0000;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	word_t     in_inst;
	word_t     in_pc;
	logic      mem_re;
	word_t     mem_addr;
	word_t     mem_rdata = '0;
	logic      wb_valid;
	reg_addr_t wb_addr;
	word_t     wb_data;

	string     tab_name      [NUM_TESTS];
	word_t     tab_inst      [NUM_TESTS];
	word_t     tab_pc        [NUM_TESTS];
	bit        tab_burst     [NUM_TESTS];
	bit        tab_load      [NUM_TESTS];
	reg_addr_t tab_exp_addr  [NUM_TESTS];
	word_t     tab_exp_data  [NUM_TESTS];
	word_t     tab_exp_maddr [NUM_TESTS];
	int        issue_cyc     [NUM_TESTS];
	bit        test_err      [NUM_TESTS];

	word_t ref_regs [32];
	word_t rng_state = 32'hdb45_68e2;
	word_t next_pc   = 32'h0000_0100;
	int    n_tests   = 0;
	int    cyc       = 0;
	int    err_cnt   = 0;
	int    n_pass    = 0;
	int    n_fail    = 0;
	int    exp_q [$];
	int    ld_q [$];
	logic  rd_pending = 1'b0;
	word_t rd_value   = '0;

	exec_slice u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_inst   (in_inst),
		.in_pc     (in_pc),
		.mem_re    (mem_re),
		.mem_addr  (mem_addr),
		.mem_rdata (mem_rdata),
		.wb_valid  (wb_valid),
		.wb_addr   (wb_addr),
		.wb_data   (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(negedge clk) begin
		cyc <= cyc + 1;
	end

	// Memory with one cycle of read latency.
	always @(negedge clk) begin
		if (rd_pending) begin
			mem_rdata = rd_value;
		end
		rd_pending = mem_re;
		rd_value   = mem_addr ^ MEM_XOR;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus helpers and reference model
	function automatic word_t lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic word_t enc_reg(logic [5:0] op, reg_addr_t rt, reg_addr_t ra,
	                                  reg_addr_t rb, logic [1:0] sv);
		return {1'b0, op, rt, ra, rb, sv, 8'h00};
	endfunction

	function automatic word_t enc_imm15(logic [5:0] op, reg_addr_t rt, reg_addr_t ra,
	                                    logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic word_t enc_imm20(logic [5:0] op, reg_addr_t rt, logic [19:0] imm);
		return {1'b0, op, rt, imm};
	endfunction

	task automatic model_step(input int i);
		logic [5:0] op;
		reg_addr_t  rt;
		logic [1:0] sv;
		word_t      a;
		word_t      b;
		word_t      s15;
		word_t      res;
		word_t      addr;
		op   = tab_inst[i][30:25];
		rt   = tab_inst[i][24:20];
		sv   = tab_inst[i][9:8];
		a    = ref_regs[tab_inst[i][19:15]];
		b    = ref_regs[tab_inst[i][14:10]];
		s15  = {{17{tab_inst[i][14]}}, tab_inst[i][14:0]};
		res  = '0;
		addr = '0;
		case (op)
			`OP_ADD:   res = a + b;
			`OP_SUB:   res = a - b;
			`OP_OR:    res = a | b;
			`OP_ADDI:  res = a + s15;
			`OP_ORI:   res = a | {17'h0, tab_inst[i][14:0]};
			`OP_SLLI:  res = a << tab_inst[i][14:10];
			`OP_MOVI:  res = {{12{tab_inst[i][19]}}, tab_inst[i][19:0]};
			`OP_SETHI: res = {tab_inst[i][19:0], 12'h000};
			`OP_LWI: begin
				addr = a + {s15[29:0], 2'b00}; // Word offset.
				res  = addr ^ MEM_XOR;
			end
			`OP_LW: begin
				addr = a + (b << sv);
				res  = addr ^ MEM_XOR;
			end
			`OP_JAL: begin
				rt  = `LP_REG;
				res = tab_pc[i] + 32'd4;
			end
			default: res = '0;
		endcase
		tab_exp_addr[i]  = rt;
		tab_exp_data[i]  = res;
		tab_exp_maddr[i] = addr;
		tab_load[i]      = (op == `OP_LWI) || (op == `OP_LW);
		if (rt != 5'd0) begin
			ref_regs[rt] = res;
		end
	endtask

	task automatic add_test(input string name, input word_t inst, input bit burst);
		tab_name[n_tests]  = name;
		tab_inst[n_tests]  = inst;
		tab_pc[n_tests]    = next_pc;
		tab_burst[n_tests] = burst;
		model_step(n_tests);
		next_pc = next_pc + 32'd4;
		n_tests++;
	endtask

	task automatic build_table();
		word_t r;
		add_test("movi_pos", enc_imm20(`OP_MOVI, 5'd1, 20'h12345), 1'b0);
		add_test("movi_neg", enc_imm20(`OP_MOVI, 5'd2, 20'hf8001), 1'b0);
		r = lcg_next();
		add_test("sethi_r3", enc_imm20(`OP_SETHI, 5'd3, r[31:12]), 1'b0);
		r = lcg_next();
		add_test("ori_r3", enc_imm15(`OP_ORI, 5'd3, 5'd3, r[14:0]), 1'b0);
		r = lcg_next();
		add_test("sethi_r4", enc_imm20(`OP_SETHI, 5'd4, r[31:12]), 1'b0);
		r = lcg_next();
		// Top immediate bit set, so zero extension shows.
		add_test("ori_r4", enc_imm15(`OP_ORI, 5'd4, 5'd4, {1'b1, r[13:0]}), 1'b0);
		add_test("addi_neg", enc_imm15(`OP_ADDI, 5'd5, 5'd3, 15'h7ff0), 1'b0);
		add_test("addi_pos", enc_imm15(`OP_ADDI, 5'd6, 5'd4, 15'h0123), 1'b0);
		add_test("slli", enc_imm15(`OP_SLLI, 5'd7, 5'd3, {5'd13, 10'h000}), 1'b0);
		add_test("add", enc_reg(`OP_ADD, 5'd8, 5'd3, 5'd4, 2'd0), 1'b0);
		add_test("sub", enc_reg(`OP_SUB, 5'd9, 5'd3, 5'd4, 2'd0), 1'b0);
		add_test("or", enc_reg(`OP_OR, 5'd10, 5'd3, 5'd4, 2'd0), 1'b0);
		add_test("movi_base", enc_imm20(`OP_MOVI, 5'd11, 20'h01000), 1'b0);
		add_test("lwi_neg", enc_imm15(`OP_LWI, 5'd12, 5'd11, 15'h7ffe), 1'b0);
		add_test("lwi_pos", enc_imm15(`OP_LWI, 5'd13, 5'd11, 15'h0010), 1'b0);
		add_test("movi_idx", enc_imm20(`OP_MOVI, 5'd14, 20'h00007), 1'b0);
		add_test("lw_sv0", enc_reg(`OP_LW, 5'd15, 5'd11, 5'd14, 2'd0), 1'b0);
		add_test("lw_sv3", enc_reg(`OP_LW, 5'd16, 5'd11, 5'd14, 2'd3), 1'b0);
		add_test("jal", enc_imm20(`OP_JAL, 5'd0, 20'h00000), 1'b0);
		add_test("burst_add", enc_reg(`OP_ADD, 5'd17, 5'd1, 5'd2, 2'd0), 1'b0);
		add_test("burst_or", enc_reg(`OP_OR, 5'd18, 5'd3, 5'd4, 2'd0), 1'b1);
		add_test("burst_sub", enc_reg(`OP_SUB, 5'd19, 5'd1, 5'd2, 2'd0), 1'b1);
		add_test("movi_r0", enc_imm20(`OP_MOVI, 5'd0, 20'h0abcd), 1'b0);
		add_test("add_r0", enc_reg(`OP_ADD, 5'd20, 5'd8, 5'd0, 2'd0), 1'b0);
		add_test("read_lp", enc_reg(`OP_ADD, 5'd21, `LP_REG, 5'd0, 2'd0), 1'b0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Output checks
	task automatic check_mem_port();
		int i;
		assert (ld_q.size() != 0) else begin
			$display("mem_re went high with no load in flight");
			err_cnt++;
		end
		if (ld_q.size() != 0) begin
			i = ld_q.pop_front();
			assert (mem_addr == tab_exp_maddr[i]) else begin
				$display("[FAIL] %s mem_addr expected %h actual %h",
				         tab_name[i], tab_exp_maddr[i], mem_addr);
				err_cnt++;
				test_err[i] = 1'b1;
			end
			assert (cyc - issue_cyc[i] == 2) else begin
				$display("%s raised mem_re in the wrong cycle", tab_name[i]);
				err_cnt++;
				test_err[i] = 1'b1;
			end
		end
	endtask

	task automatic check_writeback();
		int i;
		assert (exp_q.size() != 0) else begin
			$display("write-back to r%0d with no instruction in flight", wb_addr);
			err_cnt++;
		end
		if (exp_q.size() != 0) begin
			i = exp_q.pop_front();
			assert (wb_addr == tab_exp_addr[i]) else begin
				$display("[FAIL] %s wb_addr expected %0d actual %0d",
				         tab_name[i], tab_exp_addr[i], wb_addr);
				err_cnt++;
				test_err[i] = 1'b1;
			end
			assert (wb_data == tab_exp_data[i]) else begin
				$display("[FAIL] %s wb_data expected %h actual %h",
				         tab_name[i], tab_exp_data[i], wb_data);
				err_cnt++;
				test_err[i] = 1'b1;
			end
			assert (cyc - issue_cyc[i] == 3) else begin
				$display("%s wrote back %0d cycles after its input instead of 3",
				         tab_name[i], cyc - issue_cyc[i]);
				err_cnt++;
				test_err[i] = 1'b1;
			end
			if (test_err[i]) begin
				n_fail++;
			end else begin
				n_pass++;
			end
			$display("test %s done, %s", tab_name[i], test_err[i] ? "with errors" : "ok");
		end
	endtask

	always @(posedge clk) begin
		if (rst_n) begin
			if (mem_re) begin
				check_mem_port();
			end
			if (wb_valid) begin
				check_writeback();
			end
		end
	end

	initial begin
		int wait_cycles;
		wait_cycles = 0;
		while (wait_cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			wait_cycles++;
		end
		$display("timeout after %0d cycles, %0d write-backs never arrived",
		         wait_cycles, exp_q.size());
		$display("FAIL: see errors above");
		$finish;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Main sequence
	initial begin
		bit reset_err;
		reset_err = 1'b0;
		rst_n    = 1'b0;
		in_valid = 1'b1; // Live load on the input while reset is held.
		in_inst  = enc_imm15(`OP_LWI, 5'd1, 5'd0, 15'h0004);
		in_pc    = '0;
		for (int r = 0; r < 32; r++) begin
			ref_regs[r] = '0;
		end
		build_table();
		assert (n_tests == NUM_TESTS) else begin
			$display("stimulus table holds %0d entries, expected %0d", n_tests, NUM_TESTS);
			err_cnt++;
		end

		repeat (5) begin
			@(negedge clk);
			assert (!wb_valid && !mem_re) else begin
				$display("wb_valid or mem_re went high during reset");
				err_cnt++;
				reset_err = 1'b1;
			end
		end
		rst_n = 1'b1;
		if (reset_err) begin
			n_fail++;
		end else begin
			n_pass++;
		end
		$display("test reset done, %s", reset_err ? "with errors" : "ok");

		for (int i = 0; i < NUM_TESTS; i++) begin
			if (i != 0 && !tab_burst[i]) begin
				in_valid = 1'b0;
				repeat (3) @(negedge clk); // Four cycles between entries.
			end
			in_valid     = 1'b1;
			in_inst      = tab_inst[i];
			in_pc        = tab_pc[i];
			issue_cyc[i] = cyc;
			exp_q.push_back(i);
			if (tab_load[i]) begin
				ld_q.push_back(i);
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_inst  = '0;

		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk); // Catch stray write-backs.

		assert (ld_q.size() == 0) else begin
			$display("%0d loads never raised mem_re", ld_q.size());
			err_cnt++;
		end

		$display("%0d of %0d tests passed, %0d failed, %0d errors",
		         n_pass, NUM_TESTS + 1, n_fail, err_cnt);
		if (err_cnt == 0 && n_pass == NUM_TESTS + 1) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* filelist.f */
+incdir+hw
hw/exec_pkg.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/operand_muxes.sv
hw/exec_alu.sv
hw/writeback_select.sv
hw/exec_slice.sv
bench/tb_exec_slice.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_exec_slice
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
